/* axis_pkg.sv */
// AXIS sideband layouts for the bridge output
// tuser is fixed at 128 bits with the upper part zero
`include "bridge_consts.svh"

package axis_pkg;

   // tuser fields, top bit first
   typedef struct packed {
      logic [`AXIS_USER_W-33:0]   pad;          // Always zero
      logic [`PBS_NUM_QUEUES-1:0] dst_ports;
      logic [`PBS_NUM_QUEUES-1:0] src_onehot;
      logic [15:0]                len;
   } axis_user_t;

   // One strobe bit per data byte
   typedef logic [`PBS_DATA_W/8-1:0] axis_strb_t;

endpackage

/* bridge_consts.svh */
// Widths and codes shared by the packages and the RTL
// The decode logic assumes 64-bit data with an 8-bit control byte
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// Packet-bus word
`define PBS_DATA_W 64
`define PBS_CTRL_W 8

// Port count; one bit per queue in the destination bitmap
`define PBS_NUM_QUEUES 8

// Source port field width, log2 of the queue count
`define PBS_SRC_W 3

// Input FIFO depth as a power of two
`define PBS_FIFO_DEPTH_BITS 2

// Control byte that marks a module header word
`define PBS_HDR_CTRL 8'hFF

// AXIS sideband
`define AXIS_USER_W 128

`endif

/* files.f */
+incdir+.
pbs_pkg.sv
axis_pkg.sv
pbs_fifo_if.sv
pbs_fallthrough_fifo.sv
pbs_hdr_decode.sv
pbs_axis_bridge.sv
pbs_axis_top.sv
tb_pbs_axis_top.sv

/* pbs_axis_bridge.sv */
// PBS to AXIS bridge: header words set tuser, data words become beats
// Output register is held while tvalid is high and tready is low
`timescale 1ns/1ps
`include "bridge_consts.svh"

module pbs_axis_bridge (
   input  logic                   clk,
   input  logic                   reset,
   pbs_fifo_if.bridge_side        fifo,
   output logic [`PBS_DATA_W-1:0] axis_tdata,
   output axis_pkg::axis_strb_t   axis_tstrb,
   output axis_pkg::axis_user_t   axis_tuser,
   output logic                   axis_tvalid,
   output logic                   axis_tlast,
   input  logic                   axis_tready
);
   import axis_pkg::*;

   typedef enum logic {
      S_HEADER,
      S_PAYLOAD
   } state_t;

   state_t                 state;
   state_t                 state_next;

   axis_user_t             user_dec;
   axis_user_t             user_held;   // From the latest header
   axis_strb_t             last_strb;
   logic [`PBS_DATA_W-1:0] data_swapped;
   logic                   is_hdr;
   logic                   is_data;
   logic                   is_last;

   logic                   out_free;
   logic                   load_beat;
   logic                   hdr_load;

   pbs_hdr_decode u_decode (
      .head         (fifo.entry),
      .user         (user_dec),
      .data_swapped (data_swapped),
      .last_strb    (last_strb),
      .is_hdr       (is_hdr),
      .is_data      (is_data),
      .is_last      (is_last)
   );

   // Output slot can take a beat this cycle
   assign out_free = !axis_tvalid || axis_tready;

   always_comb begin
      state_next  = state;
      fifo.rd_en  = 1'b0;
      load_beat   = 1'b0;
      hdr_load    = 1'b0;

      if (!fifo.empty) begin
         case (state)
            S_HEADER: begin
               if (is_hdr) begin
                  hdr_load   = 1'b1;   // A later header overwrites this one
                  fifo.rd_en = 1'b1;
               end else if (is_data) begin
                  if (out_free) begin
                     load_beat  = 1'b1;
                     fifo.rd_en = 1'b1;
                     if (!is_last) begin
                        state_next = S_PAYLOAD;   // Single-word packets stay here
                     end
                  end
               end else begin
                  fifo.rd_en = 1'b1;   // Stray word, drop it
               end
            end

            S_PAYLOAD: begin
               if (out_free) begin
                  load_beat  = 1'b1;
                  fifo.rd_en = 1'b1;
                  if (is_last) begin
                     state_next = S_HEADER;
                  end
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         user_held <= '0;
      end else if (hdr_load) begin
         user_held <= user_dec;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= S_HEADER;
         axis_tvalid <= 1'b0;
         axis_tlast  <= 1'b0;
         axis_tdata  <= '0;
         axis_tstrb  <= '0;
         axis_tuser  <= '0;
      end else begin
         state <= state_next;
         if (load_beat) begin
            axis_tvalid <= 1'b1;
            axis_tlast  <= is_last;
            axis_tdata  <= data_swapped;
            axis_tstrb  <= is_last ? last_strb : '1;   // Full word unless last
            axis_tuser  <= user_held;
         end else if (axis_tready) begin
            // Beat taken with nothing behind it
            axis_tvalid <= 1'b0;
            axis_tlast  <= 1'b0;
         end
      end
   end

endmodule

/* pbs_axis_top.sv */
// PBS write port in, AXIS master out
// Sender must hold off while pbs_rdy is low; one extra word is absorbed
`timescale 1ns/1ps
`include "bridge_consts.svh"

module pbs_axis_top (
   input  logic                   clk,
   input  logic                   reset,

   // PBS write side
   input  logic [`PBS_DATA_W-1:0] pbs_data,
   input  logic [`PBS_CTRL_W-1:0] pbs_ctrl,
   input  logic                   pbs_wr,
   output logic                   pbs_rdy,

   // AXIS master
   output logic [`PBS_DATA_W-1:0] axis_tdata,
   output axis_pkg::axis_strb_t   axis_tstrb,
   output axis_pkg::axis_user_t   axis_tuser,
   output logic                   axis_tvalid,
   output logic                   axis_tlast,
   input  logic                   axis_tready
);
   import pbs_pkg::*;

   pbs_entry_t pbs_in;
   logic       fifo_nearly_full;

   pbs_fifo_if fifo_rd ();

   assign pbs_in  = {pbs_ctrl, pbs_data};   // Control byte on top
   assign pbs_rdy = !fifo_nearly_full;

   pbs_fallthrough_fifo u_fifo (
      .clk         (clk),
      .reset       (reset),
      .din         (pbs_in),
      .wr_en       (pbs_wr),
      .nearly_full (fifo_nearly_full),
      .fifo        (fifo_rd.fifo_side)
   );

   pbs_axis_bridge u_bridge (
      .clk         (clk),
      .reset       (reset),
      .fifo        (fifo_rd.bridge_side),
      .axis_tdata  (axis_tdata),
      .axis_tstrb  (axis_tstrb),
      .axis_tuser  (axis_tuser),
      .axis_tvalid (axis_tvalid),
      .axis_tlast  (axis_tlast),
      .axis_tready (axis_tready)
   );

endmodule

/* pbs_fallthrough_fifo.sv */
// First-word-fall-through FIFO, head always on fifo.entry
// Writes while full are dropped; nearly_full leaves one slot of slack
`timescale 1ns/1ps
`include "bridge_consts.svh"

module pbs_fallthrough_fifo (
   input  logic                 clk,
   input  logic                 reset,
   input  pbs_pkg::pbs_entry_t  din,
   input  logic                 wr_en,
   output logic                 nearly_full,
   pbs_fifo_if.fifo_side        fifo
);
   import pbs_pkg::*;

   localparam int DEPTH = 1 << `PBS_FIFO_DEPTH_BITS;

   // Occupancy thresholds at the count width
   localparam logic [`PBS_FIFO_DEPTH_BITS:0] FULL_CNT = {1'b1, {`PBS_FIFO_DEPTH_BITS{1'b0}}};
   localparam logic [`PBS_FIFO_DEPTH_BITS:0] NEAR_CNT = FULL_CNT - 1'b1;

   pbs_entry_t mem [DEPTH];

   logic [`PBS_FIFO_DEPTH_BITS-1:0] wr_ptr;
   logic [`PBS_FIFO_DEPTH_BITS-1:0] rd_ptr;
   logic [`PBS_FIFO_DEPTH_BITS:0]   count;
   logic                            do_wr;
   logic                            do_rd;

   assign do_wr = wr_en && (count != FULL_CNT);
   assign do_rd = fifo.rd_en && (count != '0);   // Guard against a pop on empty

   // Storage
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Idle or simultaneous push and pop
         endcase
      end
   end

   // Head falls through with no read latency
   assign fifo.entry  = mem[rd_ptr];
   assign fifo.empty  = (count == '0);
   assign nearly_full = (count >= NEAR_CNT);

endmodule

/* pbs_fifo_if.sv */
// Read side of the input FIFO
// entry is only meaningful while empty is low
`timescale 1ns/1ps

interface pbs_fifo_if;
   import pbs_pkg::*;

   pbs_entry_t entry;   // Head of the FIFO
   logic       empty;
   logic       rd_en;   // Pops the head at the next edge

   modport fifo_side (
      output entry,
      output empty,
      input  rd_en
   );

   modport bridge_side (
      input  entry,
      input  empty,
      output rd_en
   );

endinterface

/* pbs_hdr_decode.sv */
// Combinational decode of the FIFO head word
// Only one-hot control bytes count as last words; 0 and FF are the other legal codes
`timescale 1ns/1ps
`include "bridge_consts.svh"

module pbs_hdr_decode (
   input  pbs_pkg::pbs_entry_t   head,
   output axis_pkg::axis_user_t  user,
   output logic [`PBS_DATA_W-1:0] data_swapped,
   output axis_pkg::axis_strb_t  last_strb,
   output logic                  is_hdr,
   output logic                  is_data,
   output logic                  is_last
);
   import pbs_pkg::*;

   pbs_hdr_t                   hdr;
   pbs_ctrl_t                  ctrl;
   logic [`PBS_NUM_QUEUES-1:0] src_onehot;
   logic                       ctrl_onehot;

   assign ctrl = head.ctrl;
   assign hdr  = head.word.hdr;   // Header view of the word

   always_comb begin
      src_onehot = '0;
      src_onehot[hdr.src_port] = 1'b1;
   end

   assign user.pad        = '0;
   assign user.dst_ports  = hdr.dst_ports;
   assign user.src_onehot = src_onehot;
   assign user.len        = hdr.len;

   // Byte lane i takes lane 7-i
   always_comb begin
      for (int i = 0; i < `PBS_DATA_W/8; i++) begin
         data_swapped[i*8 +: 8] = head.word.lanes[`PBS_DATA_W/8-1-i];
      end
   end

   // Control bit 7-k set means k+1 valid bytes
   always_comb begin
      last_strb = '0;
      for (int k = 0; k < `PBS_CTRL_W; k++) begin
         if (ctrl == (pbs_ctrl_t'(1) << (`PBS_CTRL_W-1-k))) begin
            last_strb = {`PBS_CTRL_W{1'b1}} >> (`PBS_CTRL_W-1-k);
         end
      end
   end

   // Exactly one bit set
   assign ctrl_onehot = (ctrl != '0) && ((ctrl & (ctrl - 1'b1)) == '0);

   assign is_hdr  = (ctrl == `PBS_HDR_CTRL);
   assign is_last = ctrl_onehot;
   assign is_data = (ctrl == '0) || ctrl_onehot;   // Neither class means a stray word

endmodule

/* pbs_pkg.sv */
// Packet-bus word layouts
// Header fields sit at fixed bit positions: length at 0, source at 16, destination at 48
`include "bridge_consts.svh"

package pbs_pkg;

   // One control byte per word; FF is a header, 0 is payload, one-hot ends a packet
   typedef logic [`PBS_CTRL_W-1:0] pbs_ctrl_t;

   // Module header, top bit first
   typedef struct packed {
      logic [7:0]                 rsvd_hi;
      logic [`PBS_NUM_QUEUES-1:0] dst_ports;   // Bitmap at bit 48
      logic [28:0]                rsvd_mid;
      logic [`PBS_SRC_W-1:0]      src_port;    // Port number at bit 16
      logic [15:0]                len;         // Bytes in the packet
   } pbs_hdr_t;

   // Same 64 bits read as a header or as byte lanes
   typedef union packed {
      pbs_hdr_t                          hdr;
      logic [`PBS_DATA_W/8-1:0][7:0]     lanes;   // Lane 0 is the low byte
   } pbs_word_t;

   // One FIFO entry
   typedef struct packed {
      pbs_ctrl_t ctrl;
      pbs_word_t word;
   } pbs_entry_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the PBS to AXIS bridge testbench with Verilator.
# Exit status is nonzero if the build fails or the log holds the fail message.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   --top-module tb_pbs_axis_top \
   -f files.f \
   -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
   echo "Simulation failed, see sim.log"
   exit 1
fi

echo "Simulation passed"

/* tb_pbs_axis_top.sv */
// Random packets through pbs_axis_top, checked by assertions against a queue of expected beats
// Needs timing and concurrent assertion support, e.g. Verilator with --timing --assert
`timescale 1ns/1ps
`include "bridge_consts.svh"

module tb_pbs_axis_top;

   localparam int NUM_PACKETS     = 40;
   localparam int WATCHDOG_CYCLES = NUM_PACKETS * 6 * 20;

   typedef struct packed {
      logic [`PBS_DATA_W-1:0]   tdata;
      logic [`PBS_DATA_W/8-1:0] tstrb;
      logic [`AXIS_USER_W-1:0]  tuser;
      logic                     tlast;
   } beat_t;

   logic                     clk = 1'b0;
   logic                     reset;
   logic [`PBS_DATA_W-1:0]   pbs_data;
   logic [`PBS_CTRL_W-1:0]   pbs_ctrl;
   logic                     pbs_wr;
   logic                     pbs_rdy;
   logic [`PBS_DATA_W-1:0]   axis_tdata;
   logic [`PBS_DATA_W/8-1:0] axis_tstrb;
   logic [`AXIS_USER_W-1:0]  axis_tuser;
   logic                     axis_tvalid;
   logic                     axis_tlast;
   logic                     axis_tready;

   beat_t exp_q[$];
   beat_t exp_front    = '0;   // Mirror of the queue head for the assertions
   logic  exp_avail    = 1'b0;
   logic  accepted     = 1'b0;
   logic  hold_ready   = 1'b1;
   int    errors       = 0;
   int    beats_pushed = 0;
   int    beats_seen   = 0;
   int    words_sent   = 0;

   always #2 clk = ~clk;

   pbs_axis_top dut (
      .clk         (clk),
      .reset       (reset),
      .pbs_data    (pbs_data),
      .pbs_ctrl    (pbs_ctrl),
      .pbs_wr      (pbs_wr),
      .pbs_rdy     (pbs_rdy),
      .axis_tdata  (axis_tdata),
      .axis_tstrb  (axis_tstrb),
      .axis_tuser  (axis_tuser),
      .axis_tvalid (axis_tvalid),
      .axis_tlast  (axis_tlast),
      .axis_tready (axis_tready)
   );

   // Sink side, stalls at random once the directed stall is over
   initial begin
      axis_tready = 1'b0;
      forever begin
         @(posedge clk);
         #0.5;
         if (hold_ready || reset) begin
            axis_tready = 1'b0;
         end else begin
            axis_tready = ($urandom % 4) != 0;
         end
      end
   end

   task automatic refresh_front();
      exp_avail = exp_q.size() > 0;
      if (exp_q.size() > 0) begin
         exp_front = exp_q[0];
      end
   endtask

   // A beat taken at the rising edge leaves the queue at the falling edge
   always @(posedge clk) begin
      accepted <= !reset && axis_tvalid && axis_tready;
   end

   always @(negedge clk) begin
      if (accepted) begin
         beats_seen++;
         if (exp_q.size() > 0) begin
            exp_q.delete(0);
         end
         refresh_front();
      end
   end

   a_reset_idle: assert property (@(posedge clk) reset |=> !axis_tvalid && !axis_tlast
                                  && axis_tdata == '0 && axis_tstrb == '0 && axis_tuser == '0)
      else begin
         errors++;
         $display("ERROR: AXIS outputs not idle after a reset cycle");
      end

   a_beat_known: assert property (@(posedge clk) disable iff (reset)
                                  axis_tvalid && axis_tready |-> exp_avail)
      else begin
         errors++;
         $display("ERROR: beat accepted while no beat was expected");
      end

   a_tdata: assert property (@(posedge clk) disable iff (reset)
                             axis_tvalid && axis_tready && exp_avail |-> axis_tdata == exp_front.tdata)
      else begin
         errors++;
         $display("FAILED axis_tdata: got %h expected %h",
                  $sampled(axis_tdata), $sampled(exp_front.tdata));
      end

   a_tstrb: assert property (@(posedge clk) disable iff (reset)
                             axis_tvalid && axis_tready && exp_avail |-> axis_tstrb == exp_front.tstrb)
      else begin
         errors++;
         $display("FAILED axis_tstrb: got %h expected %h",
                  $sampled(axis_tstrb), $sampled(exp_front.tstrb));
      end

   a_tuser: assert property (@(posedge clk) disable iff (reset)
                             axis_tvalid && axis_tready && exp_avail |-> axis_tuser == exp_front.tuser)
      else begin
         errors++;
         $display("FAILED axis_tuser: got %h expected %h",
                  $sampled(axis_tuser), $sampled(exp_front.tuser));
      end

   a_tlast: assert property (@(posedge clk) disable iff (reset)
                             axis_tvalid && axis_tready && exp_avail |-> axis_tlast == exp_front.tlast)
      else begin
         errors++;
         $display("FAILED axis_tlast: got %h expected %h",
                  $sampled(axis_tlast), $sampled(exp_front.tlast));
      end

   // Stalled beat must not move
   a_hold: assert property (@(posedge clk) disable iff (reset)
                            axis_tvalid && !axis_tready |=> axis_tvalid && $stable(axis_tdata)
                            && $stable(axis_tstrb) && $stable(axis_tuser) && $stable(axis_tlast))
      else begin
         errors++;
         $display("ERROR: AXIS beat changed while tvalid was high and tready low");
      end

   function automatic logic [`PBS_DATA_W-1:0] byte_reverse(input logic [`PBS_DATA_W-1:0] w);
      logic [`PBS_DATA_W-1:0] r;
      r = {<<8{w}};
      return r;
   endfunction

   function automatic logic [7:0] strb_for(input int nbytes);
      logic [7:0] s;
      s = 8'h00;
      for (int i = 0; i < 8; i++) begin
         if (i < nbytes) begin
            s = s | (8'h01 << i);
         end
      end
      return s;
   endfunction

   function automatic logic [`AXIS_USER_W-1:0] expected_user(input logic [7:0] dst,
                                                              input logic [2:0] src,
                                                              input logic [15:0] len);
      return {96'd0, dst, 8'h01 << src, len};
   endfunction

   // Called 0.5 ns after a rising edge, returns at the same phase
   task automatic write_word(input logic [`PBS_DATA_W-1:0] data, input logic [7:0] ctrl);
      int gap;
      while (!pbs_rdy) begin
         @(posedge clk);
         #0.5;
      end
      pbs_data = data;
      pbs_ctrl = ctrl;
      pbs_wr   = 1'b1;
      @(posedge clk);
      #0.5;
      pbs_wr = 1'b0;
      words_sent++;
      gap = int'($urandom % 3);
      repeat (gap) begin
         @(posedge clk);
         #0.5;
      end
   endtask

   task automatic push_beat(input beat_t b);
      exp_q.push_back(b);
      beats_pushed++;
      refresh_front();
   endtask

   // Optional stray word and decoy header ahead of the real header
   task automatic send_packet(input int nwords, input int nbytes, input bit extra_hdr,
                              input bit stray);
      logic [7:0]             dst;
      logic [2:0]             src;
      logic [15:0]            len;
      logic [`PBS_DATA_W-1:0] word;
      logic [7:0]             ctrl;
      logic [7:0]             stray_ctrl;
      beat_t                  b;
      if (stray) begin
         stray_ctrl = ($urandom % 2) == 0 ? 8'h03 : 8'h81;   // Neither one-hot nor FF
         write_word({$urandom, $urandom}, stray_ctrl);
      end
      if (extra_hdr) begin
         write_word({$urandom, $urandom}, 8'hFF);   // Overwritten by the next header
      end
      dst = 8'($urandom);
      src = 3'($urandom);
      len = 16'((nwords - 1) * 8 + nbytes);
      word = {$urandom, $urandom};   // Reserved bits stay random
      word[55:48] = dst;
      word[18:16] = src;
      word[15:0]  = len;
      write_word(word, 8'hFF);
      for (int i = 0; i < nwords; i++) begin
         word = {$urandom, $urandom};
         ctrl = (i == nwords - 1) ? 8'h80 >> (nbytes - 1) : 8'h00;
         b.tdata = byte_reverse(word);
         b.tstrb = (i == nwords - 1) ? strb_for(nbytes) : 8'hFF;
         b.tuser = expected_user(dst, src, len);
         b.tlast = (i == nwords - 1);
         push_beat(b);
         write_word(word, ctrl);
      end
   endtask

   initial begin
      int sent_before;
      void'($urandom(76));
      reset    = 1'b1;
      pbs_data = '0;
      pbs_ctrl = '0;
      pbs_wr   = 1'b0;
      repeat (4) @(posedge clk);
      #0.5;
      reset = 1'b0;
      assert (pbs_rdy === 1'b1) else begin
         errors++;
         $display("FAILED pbs_rdy: got %h expected %h", pbs_rdy, 1'b1);
      end

      // Sink held off: stray, two headers, one beat in the output register, three buffered
      sent_before = words_sent;
      fork
         send_packet(6, 3, 1'b1, 1'b1);
         begin
            repeat (40) @(posedge clk);
            #0.5;
            assert (pbs_rdy === 1'b0) else begin
               errors++;
               $display("FAILED pbs_rdy: got %h expected %h", pbs_rdy, 1'b0);
            end
            if (words_sent - sent_before != 7) begin
               errors++;
               $display("ERROR: %0d words written under stall, expected 7",
                        words_sent - sent_before);
            end
            hold_ready = 1'b0;
         end
      join

      for (int p = 0; p < NUM_PACKETS; p++) begin
         send_packet(1 + int'($urandom % 6), 1 + int'($urandom % 8),
                     ($urandom % 4) == 0, ($urandom % 4) == 0);
      end

      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);
      if (beats_seen != beats_pushed) begin
         errors++;
         $display("ERROR: %0d beats accepted but %0d were sent", beats_seen, beats_pushed);
      end

      $display("Beats %0d of %0d, words written %0d, errors %0d",
               beats_seen, beats_pushed, words_sent, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("ERROR: watchdog expired after %0d cycles with %0d beats outstanding",
               WATCHDOG_CYCLES, exp_q.size());
      $display("=== FAIL ===");
      $finish;
   end

endmodule
